// ==== Bender.yml ====
package:
  name: sdram_sched

sources:
  - include_dirs:
      - .
    files:
      - sdram_cmd_pkg.sv
      - sdram_addr_pkg.sv
      - port_req_if.sv
      - bank_state_if.sv
      - port_stage.sv
      - bank_tracker.sv
      - command_issue.sv
      - sdram_sched_top.sv
      - target: test
        files:
          - sdram_sched_checker.sv
          - tb_sdram_sched.sv

// ==== bank_state_if.sv ====
`timescale 1ns/1ps

interface bank_state_if;
  sdram_addr_pkg::page_t     open_page;
  logic                      page_open;
  logic                      last_was_write;
  logic                      refresh_due;
  logic                      actv_done;
  sdram_cmd_pkg::sdram_cmd_t issued_cmd;  // NOOP unless issued last cycle
  logic                      load_page;
  sdram_addr_pkg::page_t     new_page;

  modport tracker (
    output open_page, page_open, last_was_write, refresh_due, actv_done,
    input  issued_cmd, load_page, new_page
  );

  modport issue (
    input  open_page, page_open, last_was_write, refresh_due, actv_done,
    output issued_cmd, load_page, new_page
  );
endinterface

// ==== bank_tracker.sv ====
`timescale 1ns/1ps
`include "sdram_defines.svh"

module bank_tracker (
  input  logic          INPUT_CLK,
  input  logic          RST,
  input  logic          refresh_strobe,
  bank_state_if.tracker to_issue
);
  logic       refresh_ack;  // strobe level at the last ARSR
  logic [2:0] actv_cnt;

  assign to_issue.actv_done = (actv_cnt == `SDRAM_ACTV_TIMEOUT);

  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      to_issue.page_open      <= 1'b0;
      to_issue.last_was_write <= 1'b0;
      to_issue.refresh_due    <= 1'b0;
      refresh_ack             <= 1'b0;
      actv_cnt                <= 3'(`SDRAM_ACTV_TIMEOUT);
    end
    else
    begin
      // refresh request is a toggle
      to_issue.refresh_due <= refresh_strobe ^ refresh_ack;

      case (to_issue.issued_cmd)
        sdram_cmd_pkg::ACTV: to_issue.page_open <= 1'b1;
        sdram_cmd_pkg::PRCH: to_issue.page_open <= 1'b0;
        sdram_cmd_pkg::WRTE: to_issue.last_was_write <= 1'b1;
        sdram_cmd_pkg::READ: to_issue.last_was_write <= 1'b0;
        sdram_cmd_pkg::ARSR: refresh_ack <= refresh_strobe;
        default: ;
      endcase

      if (to_issue.issued_cmd == sdram_cmd_pkg::ACTV)
        actv_cnt <= 3'd0;  // row just opened
      else if (!to_issue.actv_done)
        actv_cnt <= actv_cnt + 3'd1;
    end
  end

  // page comes from the issue logic at the ACTV edge
  always_ff @(posedge INPUT_CLK)
  begin
    if (to_issue.load_page)
      to_issue.open_page <= to_issue.new_page;
  end

endmodule

// ==== command_issue.sv ====
`timescale 1ns/1ps
`include "sdram_defines.svh"

module command_issue (
  input  logic                         INPUT_CLK,
  input  logic                         RST,
  port_req_if.issue_dst                rand_if,
  port_req_if.issue_dst                bulk_if,
  bank_state_if.issue                  bank_if,
  output sdram_cmd_pkg::sdram_cmd_t    cmd,
  output logic [`SDRAM_PIN_ADDR_W-1:0] pin_addr,
  output sdram_addr_pkg::bank_t        bank,
  output logic                         rand_grant,
  output logic                         bulk_grant,
  output logic [`SDRAM_MASK_W-1:0]     we_mask
);
  sdram_cmd_pkg::wait_cnt_t     wait_cnt;
  sdram_cmd_pkg::sdram_cmd_t    next_cmd;
  sdram_addr_pkg::port_req_t    sel;
  logic [`SDRAM_PIN_ADDR_W-1:0] next_addr;
  logic                         in_gap;   // the NOOP stroke after a command
  logic                         last_rw;
  logic                         hit_bulk;
  logic                         hit_rand;
  logic                         hit_any;
  logic                         use_bulk;
  logic                         wait_done;
  logic                         on_page_ok;
  logic                         want;
  logic                         issue;

  // --------------------------------------------------------------------
  // port choice, bulk first
  // --------------------------------------------------------------------
  assign hit_bulk = bulk_if.hit && bulk_if.hit_now;  // held last cycle and still holds
  assign hit_rand = rand_if.hit && rand_if.hit_now;
  assign hit_any  = hit_bulk || hit_rand;
  assign use_bulk = hit_bulk || (!hit_rand && bulk_if.req);
  assign sel      = use_bulk ? bulk_if.payload : rand_if.payload;

  always_comb
  begin
    if (hit_any)
      next_cmd = sel.we ? sdram_cmd_pkg::WRTE : sdram_cmd_pkg::READ;
    else if (bank_if.page_open)
      next_cmd = bank_if.actv_done ? sdram_cmd_pkg::PRCH : sdram_cmd_pkg::NOOP;
    else if (bank_if.refresh_due)
      next_cmd = sdram_cmd_pkg::ARSR;
    else if (bulk_if.req || rand_if.req)
      next_cmd = sdram_cmd_pkg::ACTV;
    else
      next_cmd = sdram_cmd_pkg::NOOP;
  end

  always_comb
  begin
    case (next_cmd)
      sdram_cmd_pkg::ACTV:
        next_addr = {sel.addr.row[`SDRAM_ROW_W-1 -: 2], 1'b0,
                     sel.addr.row[`SDRAM_ROW_W-3:0]};
      sdram_cmd_pkg::READ,
      sdram_cmd_pkg::WRTE:
        next_addr = {sel.addr.col, 1'b0};
      default:
        next_addr = `SDRAM_PRCH_ALL_ADDR;
    endcase
  end

  // --------------------------------------------------------------------
  // issue gate
  // --------------------------------------------------------------------
  assign wait_done  = (wait_cnt == sdram_cmd_pkg::wait_cnt_t'(`SDRAM_WAIT_IDLE));
  assign want       = bulk_if.req || rand_if.req || bank_if.refresh_due;
  // back-to-back access in the same direction skips the wait
  assign on_page_ok = hit_any && last_rw && (bank_if.last_was_write == sel.we);
  assign issue      = !in_gap && (next_cmd != sdram_cmd_pkg::NOOP) &&
                      ((wait_done && want) || on_page_ok);

  assign bank_if.issued_cmd = cmd;
  assign bank_if.load_page  = issue && (next_cmd == sdram_cmd_pkg::ACTV);
  assign bank_if.new_page   = '{row: sel.addr.row, bank: sel.addr.bank};

  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
      wait_cnt <= sdram_cmd_pkg::wait_cnt_t'(`SDRAM_WAIT_IDLE);
    else if (in_gap)
    begin
      case (cmd)
        sdram_cmd_pkg::ARSR: wait_cnt <= sdram_cmd_pkg::wait_cnt_t'(`SDRAM_WAIT_LOAD_ARSR);
        sdram_cmd_pkg::NOOP: wait_cnt <= sdram_cmd_pkg::wait_cnt_t'(`SDRAM_WAIT_IDLE);
        default:             wait_cnt <= sdram_cmd_pkg::wait_cnt_t'(`SDRAM_WAIT_LOAD_OTHER);
      endcase
    end
    else if (!wait_done)
      wait_cnt <= wait_cnt + 4'd1;
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      cmd        <= sdram_cmd_pkg::NOOP;
      pin_addr   <= `SDRAM_PRCH_ALL_ADDR;
      bank       <= '0;
      rand_grant <= 1'b0;
      bulk_grant <= 1'b0;
      we_mask    <= '0;
      in_gap     <= 1'b0;
      last_rw    <= 1'b0;
    end
    else
    begin
      cmd        <= issue ? next_cmd : sdram_cmd_pkg::NOOP;
      in_gap     <= issue;
      bulk_grant <= issue && hit_any && use_bulk;
      rand_grant <= issue && hit_any && !use_bulk;
      if (issue)
      begin
        pin_addr <= next_addr;
        last_rw  <= hit_any;
        if (next_cmd == sdram_cmd_pkg::ACTV)
          bank <= sel.addr.bank;
        else if (hit_any)
          bank <= bank_if.open_page.bank;
        if (hit_any)
          we_mask <= sel.mask;  // mask of the served port
      end
    end
  end

endmodule

// ==== port_req_if.sv ====
`timescale 1ns/1ps

interface port_req_if;
  logic                      req;      // registered request level
  sdram_addr_pkg::port_req_t payload;
  logic                      hit_now;  // live page hit
  logic                      hit;      // page hit, one cycle old

  modport port_src (
    output req, payload, hit_now, hit
  );

  modport issue_dst (
    input req, payload, hit_now, hit
  );
endinterface

// ==== port_stage.sv ====
`timescale 1ns/1ps

module port_stage (
  input  logic                      INPUT_CLK,
  input  logic                      RST,
  input  logic                      req,
  input  sdram_addr_pkg::port_req_t payload,
  input  sdram_addr_pkg::page_t     open_page,
  input  logic                      page_open,
  input  logic                      refresh_due,
  port_req_if.port_src              to_issue
);
  sdram_addr_pkg::page_t req_page;
  logic                  hit_now;

  assign req_page = '{row: payload.addr.row, bank: payload.addr.bank};

  // live request on the open row and bank, nothing blocking
  assign hit_now = req && !refresh_due && page_open && (req_page == open_page);
  assign to_issue.hit_now = hit_now;

  always_ff @(posedge INPUT_CLK)
  begin
    if (!RST)
    begin
      to_issue.req <= 1'b0;
      to_issue.hit <= 1'b0;
    end
    else
    begin
      to_issue.req <= req;
      to_issue.hit <= hit_now;
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    to_issue.payload <= payload;
  end

endmodule

// ==== sdram_addr_pkg.sv ====
`include "sdram_defines.svh"

package sdram_addr_pkg;

  typedef logic [`SDRAM_ROW_W-1:0]  row_t;
  typedef logic [`SDRAM_BANK_W-1:0] bank_t;
  typedef logic [`SDRAM_COL_W-1:0]  col_t;

  typedef struct packed {
    row_t  row;
    bank_t bank;
  } page_t;

  // row sits in the top bits
  typedef struct packed {
    row_t  row;
    bank_t bank;
    col_t  col;
  } req_addr_t;

  typedef struct packed {
    req_addr_t                addr;
    logic                     we;
    logic [`SDRAM_MASK_W-1:0] mask;
  } port_req_t;

endpackage

// ==== sdram_cmd_pkg.sv ====
package sdram_cmd_pkg;

  // {ras_n, cas_n, we_n}
  typedef enum logic [2:0] {
    MRST = 3'b000,  // mode register set, never issued
    ARSR = 3'b001,  // auto refresh
    PRCH = 3'b010,
    ACTV = 3'b011,
    WRTE = 3'b100,
    READ = 3'b101,
    BTRM = 3'b110,  // burst terminate, never issued
    NOOP = 3'b111
  } sdram_cmd_t;

  // post-command wait
  typedef logic [3:0] wait_cnt_t;

endpackage

// ==== sdram_defines.svh ====
`ifndef SDRAM_DEFINES_SVH
`define SDRAM_DEFINES_SVH

// request address split
`define SDRAM_REQ_ADDR_W      26
`define SDRAM_ROW_W           12
`define SDRAM_BANK_W          2
`define SDRAM_COL_W           12

// pins
`define SDRAM_PIN_ADDR_W      13
`define SDRAM_MASK_W          4
`define SDRAM_PRCH_ALL_ADDR   13'h400  // a10 set, all banks

// wait counter loads, counter runs up to the idle value
`define SDRAM_WAIT_LOAD_ARSR  3
`define SDRAM_WAIT_LOAD_OTHER 12
`define SDRAM_WAIT_IDLE       14

// min cycles between activate and precharge
`define SDRAM_ACTV_TIMEOUT    4

`endif

// ==== sdram_sched_checker.sv ====
`timescale 1ns/1ps
`include "sdram_defines.svh"

module sdram_sched_checker (
  input logic                         INPUT_CLK,
  input logic                         RST,
  input sdram_cmd_pkg::sdram_cmd_t    cmd,
  input logic [`SDRAM_PIN_ADDR_W-1:0] pin_addr,
  input logic                         rand_grant,
  input logic                         bulk_grant
);
  int unsigned fail_count = 0;  // failed assertions so far

  // the NOOP stroke after every command
  a_stroke: assert property (@(posedge INPUT_CLK) disable iff (!RST)
    cmd != sdram_cmd_pkg::NOOP |=> cmd == sdram_cmd_pkg::NOOP)
    else
    begin
      fail_count++;
      $error("command not followed by NOOP");
    end

  a_one_grant: assert property (@(posedge INPUT_CLK) disable iff (!RST)
    !(rand_grant && bulk_grant))
    else
    begin
      fail_count++;
      $error("both grants high");
    end

  a_grant_rw: assert property (@(posedge INPUT_CLK) disable iff (!RST)
    (rand_grant || bulk_grant) |-> cmd inside {sdram_cmd_pkg::READ, sdram_cmd_pkg::WRTE})
    else
    begin
      fail_count++;
      $error("grant without READ or WRTE");
    end

  a_prch_addr: assert property (@(posedge INPUT_CLK) disable iff (!RST)
    cmd == sdram_cmd_pkg::PRCH |-> pin_addr == `SDRAM_PRCH_ALL_ADDR)
    else
    begin
      fail_count++;
      $error("PRCH without precharge-all address");
    end

endmodule

// ==== sdram_sched_top.sv ====
`timescale 1ns/1ps
`include "sdram_defines.svh"

module sdram_sched_top (
  input  logic                         INPUT_CLK,
  input  logic                         RST,
  input  logic                         refresh_strobe,
  // random port
  input  logic                         rand_req,
  input  logic                         rand_we,
  input  sdram_addr_pkg::req_addr_t    rand_addr,
  input  logic [`SDRAM_MASK_W-1:0]     rand_mask,
  output logic                         rand_grant,
  // bulk port
  input  logic                         bulk_req,
  input  logic                         bulk_we,
  input  sdram_addr_pkg::req_addr_t    bulk_addr,
  input  logic [`SDRAM_MASK_W-1:0]     bulk_mask,
  output logic                         bulk_grant,
  // command side
  output sdram_cmd_pkg::sdram_cmd_t    cmd,
  output logic [`SDRAM_PIN_ADDR_W-1:0] pin_addr,
  output sdram_addr_pkg::bank_t        bank,
  output logic [`SDRAM_MASK_W-1:0]     we_mask
);
  sdram_addr_pkg::port_req_t rand_payload;
  sdram_addr_pkg::port_req_t bulk_payload;

  port_req_if   rand_if ();
  port_req_if   bulk_if ();
  bank_state_if bank_if ();

  assign rand_payload = '{addr: rand_addr, we: rand_we, mask: rand_mask};
  assign bulk_payload = '{addr: bulk_addr, we: bulk_we, mask: bulk_mask};

  // --------------------------------------------------------------------
  // input stages
  // --------------------------------------------------------------------
  // a live bulk request keeps the random port off the open page
  port_stage u_rand_stage (
    .INPUT_CLK   (INPUT_CLK),
    .RST         (RST),
    .req         (rand_req),
    .payload     (rand_payload),
    .open_page   (bank_if.open_page),
    .page_open   (bank_if.page_open),
    .refresh_due (bank_if.refresh_due || bulk_req),
    .to_issue    (rand_if.port_src)
  );

  port_stage u_bulk_stage (
    .INPUT_CLK   (INPUT_CLK),
    .RST         (RST),
    .req         (bulk_req),
    .payload     (bulk_payload),
    .open_page   (bank_if.open_page),
    .page_open   (bank_if.page_open),
    .refresh_due (bank_if.refresh_due),
    .to_issue    (bulk_if.port_src)
  );

  // --------------------------------------------------------------------
  // bank state and command issue
  // --------------------------------------------------------------------
  bank_tracker u_bank_tracker (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .refresh_strobe (refresh_strobe),
    .to_issue       (bank_if.tracker)
  );

  command_issue u_command_issue (
    .INPUT_CLK  (INPUT_CLK),
    .RST        (RST),
    .rand_if    (rand_if.issue_dst),
    .bulk_if    (bulk_if.issue_dst),
    .bank_if    (bank_if.issue),
    .cmd        (cmd),
    .pin_addr   (pin_addr),
    .bank       (bank),
    .rand_grant (rand_grant),
    .bulk_grant (bulk_grant),
    .we_mask    (we_mask)
  );

endmodule

// ==== tb_sdram_sched.sv ====
`timescale 1ns/1ps
`include "sdram_defines.svh"

module tb_sdram_sched;
  logic                         INPUT_CLK;
  logic                         RST;
  logic                         refresh_strobe;
  logic                         rand_req, rand_we, rand_grant;
  logic                         bulk_req, bulk_we, bulk_grant;
  sdram_addr_pkg::req_addr_t    rand_addr, bulk_addr;
  logic [`SDRAM_MASK_W-1:0]     rand_mask, bulk_mask, we_mask;
  sdram_cmd_pkg::sdram_cmd_t    cmd;
  logic [`SDRAM_PIN_ADDR_W-1:0] pin_addr;
  sdram_addr_pkg::bank_t        bank;

  // reference model state
  logic                      mdl_open, mdl_refresh, rand_pend, bulk_pend;
  sdram_addr_pkg::page_t     mdl_page;
  sdram_addr_pkg::port_req_t rand_exp, bulk_exp;
  int                        actv_cnt = 0;
  int                        prch_cnt = 0;

  sdram_sched_top u_sdram_sched_top (.*);

  bind sdram_sched_top sdram_sched_checker u_checker (
    .INPUT_CLK  (INPUT_CLK),
    .RST        (RST),
    .cmd        (cmd),
    .pin_addr   (pin_addr),
    .rand_grant (rand_grant),
    .bulk_grant (bulk_grant)
  );

  initial
  begin
    INPUT_CLK = 1'b0;
    forever #4 INPUT_CLK = ~INPUT_CLK;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      abort_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
  endtask

  // expected {cmd, pin address} for the model state and the served request
  function automatic logic [15:0] expect_cmd_addr(input logic open,
    input sdram_addr_pkg::page_t page, input logic refresh,
    input sdram_addr_pkg::req_addr_t a, input logic we);
    sdram_cmd_pkg::sdram_cmd_t c;
    logic [12:0]               p;
    if (refresh)
      c = open ? sdram_cmd_pkg::PRCH : sdram_cmd_pkg::ARSR;
    else if (open && page.row == a.row && page.bank == a.bank)
      c = we ? sdram_cmd_pkg::WRTE : sdram_cmd_pkg::READ;
    else
      c = open ? sdram_cmd_pkg::PRCH : sdram_cmd_pkg::ACTV;
    case (c)
      sdram_cmd_pkg::ACTV: p = {a.row[11:10], 1'b0, a.row[9:0]};
      sdram_cmd_pkg::READ, sdram_cmd_pkg::WRTE: p = {a.col, 1'b0};
      default: p = 13'h400;
    endcase
    return {c, p};
  endfunction

  function automatic sdram_addr_pkg::req_addr_t pick_addr(input sdram_addr_pkg::row_t r,
    input sdram_addr_pkg::bank_t b);
    return '{row: r, bank: b, col: 12'($urandom)};
  endfunction

  task automatic check_command();
    sdram_addr_pkg::port_req_t tgt;
    logic [15:0]               exp;
    logic                      tgt_bulk;
    if (!bulk_pend && !rand_pend && !mdl_refresh)
      abort_run("command issued with no request and no refresh pending");
    tgt_bulk = bulk_pend;  // bulk served first
    tgt      = bulk_pend ? bulk_exp : rand_exp;
    exp      = expect_cmd_addr(mdl_open, mdl_page, mdl_refresh, tgt.addr, tgt.we);
    check_value("cmd", cmd, exp[15:13]);
    check_value("pin_addr", pin_addr, exp[12:0]);
    case (cmd)
      sdram_cmd_pkg::ACTV:
      begin
        check_value("bank", bank, tgt.addr.bank);
        mdl_open = 1'b1;
        mdl_page = '{row: tgt.addr.row, bank: tgt.addr.bank};
        actv_cnt++;
      end
      sdram_cmd_pkg::PRCH:
      begin
        mdl_open = 1'b0;
        prch_cnt++;
      end
      sdram_cmd_pkg::ARSR: mdl_refresh = 1'b0;
      default:
      begin
        check_value("bank", bank, mdl_page.bank);
        check_value("bulk_grant", bulk_grant, tgt_bulk);
        check_value("rand_grant", rand_grant, !tgt_bulk);
        check_value("we_mask", we_mask, tgt.mask);
        if (tgt_bulk)
          bulk_pend = 1'b0;
        else
          rand_pend = 1'b0;
      end
    endcase
  endtask

  // ------------------------------------------------------------------
  // compare process, samples mid-cycle
  // ------------------------------------------------------------------
  initial
  begin
    forever
    begin
      @(negedge INPUT_CLK);
      if (u_sdram_sched_top.u_checker.fail_count != 0)
        abort_run("A checker assertion failed");
      if (RST && cmd != sdram_cmd_pkg::NOOP)
        check_command();
    end
  end

  // hold a request until its grant pulse
  task automatic access_port(input logic is_bulk, input sdram_addr_pkg::req_addr_t a,
    input logic we, input logic [3:0] m);
    int n;
    n = 0;
    if (is_bulk)
    begin
      {bulk_addr, bulk_we, bulk_mask, bulk_req} = {a, we, m, 1'b1};
      bulk_exp  = '{addr: a, we: we, mask: m};
      bulk_pend = 1'b1;
    end
    else
    begin
      {rand_addr, rand_we, rand_mask, rand_req} = {a, we, m, 1'b1};
      rand_exp  = '{addr: a, we: we, mask: m};
      rand_pend = 1'b1;
    end
    while (!(is_bulk ? bulk_grant : rand_grant) && n < 200)
    begin
      @(posedge INPUT_CLK);
      #1;
      n++;
    end
    if (!(is_bulk ? bulk_grant : rand_grant))
      abort_run($sformatf("Timeout waiting for the %s grant", is_bulk ? "bulk" : "random"));
    if (is_bulk)
      bulk_req = 1'b0;
    else
      rand_req = 1'b0;
    @(posedge INPUT_CLK);
    #1;
  endtask

  initial
  begin
    sdram_addr_pkg::req_addr_t a, b;
    int actv_before, prch_before, n;
    void'($urandom(88));
    {RST, refresh_strobe, rand_req, rand_we, rand_mask, bulk_req, bulk_we, bulk_mask} = '0;
    {rand_addr, bulk_addr} = '0;
    {mdl_open, mdl_refresh, rand_pend, bulk_pend} = '0;
    mdl_page = '0;
    repeat (3) @(posedge INPUT_CLK);
    #1 RST = 1'b1;

    check_value("cmd", cmd, sdram_cmd_pkg::NOOP);  // idle after reset
    check_value("pin_addr", pin_addr, 13'h400);
    check_value("bank", bank, 0);
    check_value("rand_grant", rand_grant, 0);
    check_value("bulk_grant", bulk_grant, 0);
    check_value("we_mask", we_mask, 0);

    a = pick_addr(12'($urandom), 2'($urandom));
    access_port(1'b0, a, 1'b0, 4'($urandom));
    check_value("actv count", actv_cnt, 1);
    access_port(1'b0, pick_addr(a.row, a.bank), 1'b1, 4'($urandom));  // same page write
    check_value("actv count", actv_cnt, 1);

    // another row
    a = pick_addr(a.row + 12'd1 + 12'($urandom % 64), 2'($urandom));
    access_port(1'b0, a, 1'($urandom), 4'($urandom));
    check_value("prch count", prch_cnt, 1);
    check_value("actv count", actv_cnt, 2);

    b = pick_addr(a.row, a.bank);
    fork
      access_port(1'b1, b, 1'($urandom), 4'($urandom));
      access_port(1'b0, pick_addr(a.row, a.bank), 1'($urandom), 4'($urandom));
    join

    // ------------------------------------------------------------------
    // refresh with a page open
    // ------------------------------------------------------------------
    prch_before = prch_cnt;
    actv_before = actv_cnt;
    refresh_strobe = ~refresh_strobe;
    mdl_refresh = 1'b1;
    n = 0;
    while (mdl_refresh && n < 200)
    begin
      @(posedge INPUT_CLK);
      #1;
      n++;
    end
    if (mdl_refresh)
      abort_run("Timeout waiting for the refresh command");
    check_value("prch count", prch_cnt, prch_before + 1);
    access_port(1'b0, pick_addr(a.row, a.bank), 1'b0, 4'($urandom));
    check_value("actv count", actv_cnt, actv_before + 1);

    if (u_sdram_sched_top.u_checker.fail_count == 0)
    begin
      $display("No errors");
      $finish;
    end
    else
      abort_run("A checker assertion failed");
  end

endmodule

// ==== verilog.f ====
+incdir+.
sdram_cmd_pkg.sv
sdram_addr_pkg.sv
port_req_if.sv
bank_state_if.sv
port_stage.sv
bank_tracker.sv
command_issue.sv
sdram_sched_top.sv
sdram_sched_checker.sv
tb_sdram_sched.sv
